// ==== include/video_settings.svh ====
////////////////////////////////////////////////////////////
// video settings
// raster geometry of the 1024x768 scan, note lane layout
// and the palette of the rhythm-game screen
////////////////////////////////////////////////////////////
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// horizontal scan, in pixel clocks
`define H_VISIBLE 1024
`define H_SYNC_START 1048
`define H_SYNC_END 1184
`define H_TOTAL 1344

// vertical scan, in lines
`define V_VISIBLE 768
`define V_SYNC_START 777
`define V_SYNC_END 783
`define V_TOTAL 806

// note blocks
`define NOTE_COUNT 16
`define NOTE_WIDTH 64
`define NOTE_HEIGHT 35
`define NOTE_STEP 74
// top of the B row
`define FIRST_ROW 144

// staff geometry
`define ACTION_X 72
`define STAFF_TOP 128
`define STAFF_PITCH 73
`define STAFF_LINES 8
`define STAFF_BOTTOM 639

// one pixel of scroll per tempo/64 cycles
`define TEMPO_MOVE_DIV 64

// palette, 24 bit rgb
`define COLOR_STAFF 24'hAAAAAA
`define COLOR_NATURAL 24'hFFFFFF
`define COLOR_SHARP 24'h5555FF
`define COLOR_HIGH_C 24'h00DD00
`define COLOR_HIT 24'hFFFF00
`define COLOR_MISS 24'hFF4500

`endif

// ==== hdl/raster_pkg.sv ====
////////////////////////////////////////////////////////////
// raster types
// scan coordinates, pixel color and output mode
////////////////////////////////////////////////////////////
`default_nettype none

package raster_pkg;

   // column 0..1343
   typedef logic [10:0] hcount_t;

   // line 0..805
   typedef logic [9:0] vcount_t;

   // one pixel, red in the upper byte
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } pixel_t;

   // output stage selection, driven by the mode switch
   typedef enum logic [1:0] {
      mode_game,
      mode_border,
      mode_bars
   } video_mode_t;

endpackage

`default_nettype wire

// ==== hdl/note_pkg.sv ====
////////////////////////////////////////////////////////////
// note types
// note codes, tempo count and the code to row and code
// to color rules of the lane
////////////////////////////////////////////////////////////
`default_nettype none

package note_pkg;

   `include "video_settings.svh"

   // 0 rest, 1..12 C..B, 13 high C
   typedef logic [3:0] note_code_t;

   // beat period in clock cycles
   typedef logic [25:0] tempo_t;

   // top line of a note block
   typedef raster_pkg::vcount_t note_row_t;

   // row index counts upward from B at the top of the staff
   function automatic note_row_t note_row_of(input note_code_t code);
      int unsigned idx;
      case (code)
         4'd1, 4'd2, 4'd13: idx = 6;
         4'd3, 4'd4:        idx = 5;
         4'd5:              idx = 4;
         4'd6, 4'd7:        idx = 3;
         4'd8, 4'd9:        idx = 2;
         4'd10, 4'd11:      idx = 1;
         4'd12:             idx = 0;
         // rest and unused codes land below the last scan line
         default:           return note_row_t'(`FIRST_ROW + `V_VISIBLE);
      endcase
      return note_row_t'(`FIRST_ROW + `NOTE_STEP * idx);
   endfunction

   function automatic raster_pkg::pixel_t note_color_of(input note_code_t code);
      case (code)
         // rest stays dark
         4'd0:                           return '0;
         // C# D# F# G# A#
         4'd2, 4'd4, 4'd7, 4'd9, 4'd11:  return `COLOR_SHARP;
         4'd13:                          return `COLOR_HIGH_C;
         default:                        return `COLOR_NATURAL;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== hdl/note_lane_if.sv ====
////////////////////////////////////////////////////////////
// note lane bus
// lead note position plus row and color of every note
////////////////////////////////////////////////////////////
`default_nettype none
`include "video_settings.svh"

interface note_lane_if;
   import raster_pkg::*;

   // left edge of note 0, the others follow at NOTE_WIDTH pitch
   hcount_t   lead_x;
   vcount_t   note_row   [`NOTE_COUNT];
   pixel_t    note_color [`NOTE_COUNT];

   // values hold until the lane changes them, no handshake
   modport lane (
      output lead_x,
      output note_row,
      output note_color
   );

   modport render (
      input lead_x,
      input note_row,
      input note_color
   );

endinterface

`default_nettype wire

// ==== hdl/raster_timing.sv ====
////////////////////////////////////////////////////////////
// raster timing
// 1344x806 scan counters with registered active low syncs
// and a blank covering both retraces
////////////////////////////////////////////////////////////
`default_nettype none
`include "video_settings.svh"

module raster_timing (
   input  wire logic          clock_65mhz,
   input  wire logic          reset,
   output raster_pkg::hcount_t hcount,
   output raster_pkg::vcount_t vcount,
   output logic               hsync,
   output logic               vsync,
   output logic               blank
);

   logic hblank;
   logic vblank;
   logic next_hblank;
   logic next_vblank;
   logic h_last;
   logic v_last;
   logic hblank_on;
   logic hsync_on;
   logic hsync_off;
   logic vblank_on;
   logic vsync_on;
   logic vsync_off;

   //////////////////////////////////////////////////////////
   // decode of the current position
   //////////////////////////////////////////////////////////

   // last column of the line
   assign h_last    = (hcount == `H_TOTAL - 1);
   assign hblank_on = (hcount == `H_VISIBLE - 1);
   // sync edges one column early so the registered pulse lands on time
   assign hsync_on  = (hcount == `H_SYNC_START - 1);
   assign hsync_off = (hcount == `H_SYNC_END - 1);

   // vertical events only at the end of a line
   assign v_last    = h_last && (vcount == `V_TOTAL - 1);
   assign vblank_on = h_last && (vcount == `V_VISIBLE - 1);
   assign vsync_on  = h_last && (vcount == `V_SYNC_START - 1);
   assign vsync_off = h_last && (vcount == `V_SYNC_END - 1);

   assign next_hblank = h_last ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = v_last ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   //////////////////////////////////////////////////////////
   // counters and registered outputs
   //////////////////////////////////////////////////////////

   always_ff @(posedge clock_65mhz) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= h_last ? '0 : hcount + 1'b1;
         if (h_last) begin
            vcount <= v_last ? '0 : vcount + 1'b1;
         end
         hblank <= next_hblank;
         vblank <= next_vblank;
         hsync  <= hsync_on ? 1'b0 : (hsync_off ? 1'b1 : hsync);
         vsync  <= vsync_on ? 1'b0 : (vsync_off ? 1'b1 : vsync);
         // registered with the counters so blank lines up with them
         blank  <= next_vblank | next_hblank;
      end
   end

   // line counter never runs past the end of the line
   hcount_in_line : assert property (
      @(posedge clock_65mhz) disable iff (reset) hcount < `H_TOTAL
   );

endmodule

`default_nettype wire

// ==== hdl/note_lane.sv ====
////////////////////////////////////////////////////////////
// note lane
// tempo driven beat and scroll strobes, reload of sixteen
// note rows and colors, lead note hit or miss coloring
////////////////////////////////////////////////////////////
`default_nettype none
`include "video_settings.svh"

module note_lane (
   input  wire logic             clock_65mhz,
   input  wire logic             reset,
   input  wire logic [63:0]      next_notes,
   input  wire note_pkg::tempo_t tempo,
   input  wire logic             playing_correct,
   note_lane_if.lane             lane
);
   import raster_pkg::*;
   import note_pkg::*;

   tempo_t     tempo_q;
   tempo_t     move_period;
   tempo_t     beat_count;
   tempo_t     move_count;
   note_code_t lead_code_q;
   note_code_t lead_code;
   logic       beat;
   logic       move;

   //////////////////////////////////////////////////////////
   // tempo strobes
   //////////////////////////////////////////////////////////

   // one note width of scroll per beat
   assign move_period = tempo_t'(tempo_q / `TEMPO_MOVE_DIV);
   assign beat = (beat_count == tempo_q - 1'b1);
   assign move = (move_count == move_period - 1'b1);

   always_ff @(posedge clock_65mhz) begin
      if (reset) begin
         // tempo only sampled here
         tempo_q    <= tempo;
         beat_count <= '0;
         move_count <= '0;
      end else begin
         beat_count <= beat ? '0 : beat_count + 1'b1;
         move_count <= move ? '0 : move_count + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////
   // lane state
   //////////////////////////////////////////////////////////

   // on a beat the lead note is the one arriving in the new word
   assign lead_code = beat ? next_notes[3:0] : lead_code_q;

   always_ff @(posedge clock_65mhz) begin
      if (reset) begin
         lane.lead_x <= hcount_t'(`H_VISIBLE - 1);
         lead_code_q <= '0;
         for (int k = 0; k < `NOTE_COUNT; k++) begin
            lane.note_row[k]   <= note_row_of('0);
            lane.note_color[k] <= '0;
         end
      end else begin
         // scroll wins over the snap back to the action line
         if (move) begin
            lane.lead_x <= lane.lead_x - 1'b1;
         end else if (beat) begin
            lane.lead_x <= hcount_t'(`ACTION_X);
         end

         if (beat) begin
            lead_code_q <= next_notes[3:0];
            // nibble k of the word is note k
            for (int k = 0; k < `NOTE_COUNT; k++) begin
               lane.note_row[k]   <= note_row_of(next_notes[4*k +: 4]);
               lane.note_color[k] <= note_color_of(next_notes[4*k +: 4]);
            end
         end

         // lead note shows how the player is doing, overrides the reload
         if (lead_code == '0) begin
            lane.note_color[0] <= '0;
         end else if (playing_correct) begin
            lane.note_color[0] <= `COLOR_HIT;
         end else begin
            lane.note_color[0] <= `COLOR_MISS;
         end
      end
   end

   // a shorter tempo would leave the scroll strobe with a zero period
   tempo_long_enough : assert property (
      @(posedge clock_65mhz) disable iff (reset) tempo_q >= `TEMPO_MOVE_DIV
   );

endmodule

`default_nettype wire

// ==== hdl/note_renderer.sv ====
////////////////////////////////////////////////////////////
// note renderer
// draws note blocks, staff, action and boundary lines for
// the scan position, one cycle of latency
////////////////////////////////////////////////////////////
`default_nettype none
`include "video_settings.svh"

module note_renderer (
   input  wire logic                clock_65mhz,
   input  wire raster_pkg::hcount_t hcount,
   input  wire raster_pkg::vcount_t vcount,
   input  wire logic                hsync,
   input  wire logic                vsync,
   input  wire logic                blank,
   note_lane_if.render              lane,
   output raster_pkg::pixel_t       game_pixel,
   output raster_pkg::hcount_t      d_hcount,
   output raster_pkg::vcount_t      d_vcount,
   output logic                     d_hsync,
   output logic                     d_vsync,
   output logic                     d_blank
);
   import raster_pkg::*;

   pixel_t note_pix;
   pixel_t line_pix;
   logic   staff_hit;
   logic   in_staff;
   logic   edge_hit;

   //////////////////////////////////////////////////////////
   // note blocks
   //////////////////////////////////////////////////////////

   always_comb begin : note_blocks
      logic [11:0] note_left;
      note_pix = '0;
      for (int k = 0; k < `NOTE_COUNT; k++) begin
         // 12 bits so the far notes do not wrap onto the screen
         note_left = {1'b0, lane.lead_x} + 12'(`NOTE_WIDTH * k);
         // nothing drawn at or left of the action line
         if (hcount > `ACTION_X &&
             hcount >= note_left && hcount < note_left + `NOTE_WIDTH &&
             vcount >= lane.note_row[k] &&
             vcount < lane.note_row[k] + `NOTE_HEIGHT) begin
            note_pix = note_pix | lane.note_color[k];
         end
      end
   end

   //////////////////////////////////////////////////////////
   // staff and vertical lines
   //////////////////////////////////////////////////////////

   always_comb begin : staff_lines
      staff_hit = 1'b0;
      for (int i = 0; i < `STAFF_LINES; i++) begin
         if (vcount == `STAFF_TOP + `STAFF_PITCH * i)
            staff_hit = 1'b1;
      end
   end

   // staff runs from the action line to the right edge
   assign line_pix = (staff_hit && hcount >= `ACTION_X && hcount < `H_VISIBLE) ?
                     `COLOR_STAFF : '0;

   // white action line and right boundary, both span the staff height
   assign in_staff = (vcount >= `STAFF_TOP) && (vcount <= `STAFF_BOTTOM);
   assign edge_hit = in_staff && (hcount == `ACTION_X || hcount == `H_VISIBLE - 1);

   //////////////////////////////////////////////////////////
   // output register, timing delayed to match
   //////////////////////////////////////////////////////////

   always_ff @(posedge clock_65mhz) begin
      // dark during retrace
      game_pixel <= blank ? '0 : (note_pix | line_pix | {24{edge_hit}});
      d_hcount   <= hcount;
      d_vcount   <= vcount;
      d_hsync    <= hsync;
      d_vsync    <= vsync;
      d_blank    <= blank;
   end

endmodule

`default_nettype wire

// ==== hdl/video_output.sv ====
////////////////////////////////////////////////////////////
// video output
// picks game, border or color bars and registers the VGA
// pixel together with the syncs
////////////////////////////////////////////////////////////
`default_nettype none
`include "video_settings.svh"

module video_output (
   input  wire logic                    clock_65mhz,
   input  wire logic                    reset,
   input  wire raster_pkg::video_mode_t mode,
   input  wire raster_pkg::pixel_t      game_pixel,
   input  wire raster_pkg::hcount_t     d_hcount,
   input  wire raster_pkg::vcount_t     d_vcount,
   input  wire logic                    d_hsync,
   input  wire logic                    d_vsync,
   input  wire logic                    d_blank,
   output logic [7:0]                   vga_red,
   output logic [7:0]                   vga_green,
   output logic [7:0]                   vga_blue,
   output logic                         vga_hsync,
   output logic                         vga_vsync,
   output logic                         vga_blank_b
);
   import raster_pkg::*;

   pixel_t pattern;
   logic   border;

   // outline of the visible area, for adjusting the monitor
   assign border = (d_hcount == 0) || (d_hcount == `H_VISIBLE - 1) ||
                   (d_vcount == 0) || (d_vcount == `V_VISIBLE - 1);

   always_comb begin
      case (mode)
         mode_border: pattern = {24{border}};
         // bars of 64, 128 and 256 columns
         mode_bars:   pattern = {{8{d_hcount[8]}}, {8{d_hcount[7]}}, {8{d_hcount[6]}}};
         // game, and the spare encoding
         default:     pattern = game_pixel;
      endcase
   end

   always_ff @(posedge clock_65mhz) begin
      if (reset) begin
         vga_red     <= '0;
         vga_green   <= '0;
         vga_blue    <= '0;
         vga_hsync   <= 1'b1;
         vga_vsync   <= 1'b1;
         vga_blank_b <= 1'b0;
      end else begin
         vga_red     <= pattern.red;
         vga_green   <= pattern.green;
         vga_blue    <= pattern.blue;
         vga_hsync   <= d_hsync;
         vga_vsync   <= d_vsync;
         vga_blank_b <= ~d_blank;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/rhythm_video_top.sv ====
////////////////////////////////////////////////////////////
// rhythm game video core
// timing generator, note lane, renderer and VGA output
////////////////////////////////////////////////////////////
`default_nettype none

module rhythm_video_top (
   input  wire logic                    clock_65mhz,
   input  wire logic                    reset,
   input  wire raster_pkg::video_mode_t mode,
   input  wire logic [63:0]             next_notes,
   input  wire note_pkg::tempo_t        tempo,
   input  wire logic                    playing_correct,
   output logic [7:0]                   vga_red,
   output logic [7:0]                   vga_green,
   output logic [7:0]                   vga_blue,
   output logic                         vga_hsync,
   output logic                         vga_vsync,
   output logic                         vga_blank_b
);
   import raster_pkg::*;

   // scan position straight from the counters
   hcount_t hcount;
   vcount_t vcount;
   logic    hsync;
   logic    vsync;
   logic    blank;

   // one cycle later, aligned with the game pixel
   pixel_t  game_pixel;
   hcount_t d_hcount;
   vcount_t d_vcount;
   logic    d_hsync;
   logic    d_vsync;
   logic    d_blank;

   note_lane_if lane_bus ();

   raster_timing u_raster_timing (
      .clock_65mhz (clock_65mhz),
      .reset       (reset),
      .hcount      (hcount),
      .vcount      (vcount),
      .hsync       (hsync),
      .vsync       (vsync),
      .blank       (blank)
   );

   note_lane u_note_lane (
      .clock_65mhz     (clock_65mhz),
      .reset           (reset),
      .next_notes      (next_notes),
      .tempo           (tempo),
      .playing_correct (playing_correct),
      .lane            (lane_bus.lane)
   );

   note_renderer u_note_renderer (
      .clock_65mhz (clock_65mhz),
      .hcount      (hcount),
      .vcount      (vcount),
      .hsync       (hsync),
      .vsync       (vsync),
      .blank       (blank),
      .lane        (lane_bus.render),
      .game_pixel  (game_pixel),
      .d_hcount    (d_hcount),
      .d_vcount    (d_vcount),
      .d_hsync     (d_hsync),
      .d_vsync     (d_vsync),
      .d_blank     (d_blank)
   );

   // second register stage, VGA pins lag the counters by two cycles
   video_output u_video_output (
      .clock_65mhz (clock_65mhz),
      .reset       (reset),
      .mode        (mode),
      .game_pixel  (game_pixel),
      .d_hcount    (d_hcount),
      .d_vcount    (d_vcount),
      .d_hsync     (d_hsync),
      .d_vsync     (d_vsync),
      .d_blank     (d_blank),
      .vga_red     (vga_red),
      .vga_green   (vga_green),
      .vga_blue    (vga_blue),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync),
      .vga_blank_b (vga_blank_b)
   );

endmodule

`default_nettype wire

// ==== testbench/rhythm_video_checks.sv ====
////////////////////////////////////////////////////////////
// scan checker
// rebuilds the scan position from the VGA outputs, checks
// the syncs against a raster model and each visible pixel
// against the screen rules of the selected mode
////////////////////////////////////////////////////////////
`default_nettype none
`include "video_settings.svh"

module scan_checker (
   input  wire logic                    clock_65mhz,
   input  wire logic                    reset,
   input  wire raster_pkg::video_mode_t mode,
   input  wire logic                    check_en,
   input  wire logic                    random_notes,
   input  wire logic [7:0]              vga_red,
   input  wire logic [7:0]              vga_green,
   input  wire logic [7:0]              vga_blue,
   input  wire logic                    vga_hsync,
   input  wire logic                    vga_vsync,
   input  wire logic                    vga_blank_b,
   output logic                         error_seen,
   output int                           pixels_checked
);
   timeunit 1ns;
   timeprecision 1ps;
   import raster_pkg::*;

   // position rebuilt from the blank and vsync edges
   int   track_col;
   int   track_line;
   logic line_valid;
   // free running raster model for the sync checks
   int   model_h;
   int   model_v;
   logic locked;
   logic prev_blank_b;
   logic prev_vsync;

   //////////////////////////////////////////////////////////
   // expected screen content
   //////////////////////////////////////////////////////////

   // staff lines, action line and right boundary
   function automatic pixel_t line_color(input int col, input int ln);
      pixel_t p;
      logic   on_staff;
      p = '0;
      on_staff = 1'b0;
      for (int i = 0; i < `STAFF_LINES; i++) begin
         if (ln == `STAFF_TOP + `STAFF_PITCH * i)
            on_staff = 1'b1;
      end
      if (on_staff && col >= `ACTION_X)
         p = `COLOR_STAFF;
      // white vertical lines win over the grey staff
      if (ln >= `STAFF_TOP && ln <= `STAFF_BOTTOM &&
          (col == `ACTION_X || col == `H_VISIBLE - 1))
         p = 24'hFFFFFF;
      return p;
   endfunction

   function automatic pixel_t border_color(input int col, input int ln);
      if (col == 0 || col == `H_VISIBLE - 1 || ln == 0 || ln == `V_VISIBLE - 1)
         return 24'hFFFFFF;
      return '0;
   endfunction

   // eight bars of 64 columns that repeat every 512
   function automatic pixel_t bar_color(input int col);
      int     bar;
      pixel_t p;
      bar = (col / 64) % 8;
      p.red   = (bar >= 4) ? 8'hFF : 8'h00;
      p.green = (bar % 4 >= 2) ? 8'hFF : 8'h00;
      p.blue  = (bar % 2 == 1) ? 8'hFF : 8'h00;
      return p;
   endfunction

   function automatic logic is_note_color(input pixel_t p);
      return p == `COLOR_NATURAL || p == `COLOR_SHARP || p == `COLOR_HIGH_C ||
             p == `COLOR_HIT || p == `COLOR_MISS;
   endfunction

   //////////////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////////////

   task automatic compare_pixel(input string name, input pixel_t got,
                                input pixel_t expected);
      if (got !== expected && !error_seen) begin
         $display("mismatch %s at col %0d line %0d: got %h expected %h",
                  name, track_col, track_line, got, expected);
         error_seen = 1'b1;
      end
   endtask

   task automatic compare_sync(input string name, input logic got, input logic expected);
      if (got !== expected && !error_seen) begin
         $display("mismatch %s at model col %0d line %0d: got %h expected %h",
                  name, model_h, model_v, got, expected);
         error_seen = 1'b1;
      end
   endtask

   task automatic check_visible_pixel(input pixel_t pix);
      pixel_t lines;
      lines = line_color(track_col, track_line);
      pixels_checked++;
      case (mode)
         mode_border: compare_pixel("vga_rgb", pix, border_color(track_col, track_line));
         mode_bars:   compare_pixel("vga_rgb", pix, bar_color(track_col));
         default: begin
            // only lines lit with rests or left of the action line
            if (!random_notes || track_col <= `ACTION_X) begin
               compare_pixel("vga_rgb", pix, lines);
            end else if (lines == '0 && pix != '0 && !is_note_color(pix) &&
                         !error_seen) begin
               $display("mismatch vga_rgb at col %0d line %0d: got %h, not a note color",
                        track_col, track_line, pix);
               error_seen = 1'b1;
            end
         end
      endcase
   endtask

   //////////////////////////////////////////////////////////
   // per cycle sampling
   //////////////////////////////////////////////////////////

   always @(posedge clock_65mhz) begin
      if (reset) begin
         error_seen     = 1'b0;
         pixels_checked = 0;
         line_valid     = 1'b0;
         locked         = 1'b0;
         prev_blank_b   = 1'b0;
         prev_vsync     = 1'b1;
      end else begin
         // model locks on the first vsync fall at column 0 of line 777
         if (!locked && prev_vsync && !vga_vsync) begin
            locked  = 1'b1;
            model_h = 0;
            model_v = `V_SYNC_START;
         end
         if (locked) begin
            compare_sync("vga_hsync", vga_hsync,
                         !(model_h >= `H_SYNC_START && model_h < `H_SYNC_END));
            compare_sync("vga_vsync", vga_vsync,
                         !(model_v >= `V_SYNC_START && model_v < `V_SYNC_END));
            compare_sync("vga_blank_b", vga_blank_b,
                         model_h < `H_VISIBLE && model_v < `V_VISIBLE);
            model_h++;
            if (model_h == `H_TOTAL) begin
               model_h = 0;
               model_v = (model_v == `V_TOTAL - 1) ? 0 : model_v + 1;
            end
         end
         // next visible line after the vsync pulse is line 0
         if (!prev_vsync && vga_vsync) begin
            track_line = -1;
            line_valid = 1'b1;
         end
         if (vga_blank_b) begin
            if (!prev_blank_b) begin
               track_col = 0;
               track_line++;
            end else begin
               track_col++;
            end
            if (line_valid && check_en)
               check_visible_pixel({vga_red, vga_green, vga_blue});
         end
         prev_blank_b = vga_blank_b;
         prev_vsync   = vga_vsync;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/rhythm_video_tb.sv ====
////////////////////////////////////////////////////////////
// rhythm video testbench
// border, bar, rest and random note frames through the
// video core, checked pixel by pixel by the scan checker
////////////////////////////////////////////////////////////
`default_nettype none
`include "video_settings.svh"

module rhythm_video_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import raster_pkg::*;
   import note_pkg::*;

   localparam int RESET_CYCLES   = 16;
   localparam int CHECKED_FRAMES = 4;
   localparam int FRAME_PIXELS   = `H_VISIBLE * `V_VISIBLE;
   // four checked frames plus the lead-in frame fit in five
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 5 * `H_TOTAL * `V_TOTAL;
   // beat every 6400 cycles, one pixel of scroll per 100
   localparam tempo_t SHORT_TEMPO = 26'd6400;

   logic        clock_65mhz;
   logic        reset;
   video_mode_t mode;
   logic [63:0] next_notes;
   tempo_t      tempo;
   logic        playing_correct;
   logic [7:0]  vga_red;
   logic [7:0]  vga_green;
   logic [7:0]  vga_blue;
   logic        vga_hsync;
   logic        vga_vsync;
   logic        vga_blank_b;
   logic        check_en;
   logic        random_notes;
   logic        error_seen;
   int          pixels_checked;
   int          cycle_count = 0;

   rhythm_video_top DUT (
      .clock_65mhz     (clock_65mhz),
      .reset           (reset),
      .mode            (mode),
      .next_notes      (next_notes),
      .tempo           (tempo),
      .playing_correct (playing_correct),
      .vga_red         (vga_red),
      .vga_green       (vga_green),
      .vga_blue        (vga_blue),
      .vga_hsync       (vga_hsync),
      .vga_vsync       (vga_vsync),
      .vga_blank_b     (vga_blank_b)
   );

   scan_checker scan_check (
      .clock_65mhz    (clock_65mhz),
      .reset          (reset),
      .mode           (mode),
      .check_en       (check_en),
      .random_notes   (random_notes),
      .vga_red        (vga_red),
      .vga_green      (vga_green),
      .vga_blue       (vga_blue),
      .vga_hsync      (vga_hsync),
      .vga_vsync      (vga_vsync),
      .vga_blank_b    (vga_blank_b),
      .error_seen     (error_seen),
      .pixels_checked (pixels_checked)
   );

   // 50 MHz stand-in for the pixel clock, 20 ns period
   initial begin
      clock_65mhz = 1'b0;
      forever #10 clock_65mhz = ~clock_65mhz;
   end

   always @(posedge clock_65mhz) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the last test frame never ended", cycle_count);
         $display("*** FAILED ***");
         $fatal(1, "timeout");
      end
   end

   // first failed check ends the run
   initial begin
      wait (error_seen === 1'b1);
      $display("*** FAILED ***");
      $fatal(1, "stopped at the first failed check");
   end

   // mode for the next frame, then run until its vsync falls
   task automatic run_frame(input video_mode_t frame_mode, input logic enable,
                            input logic with_notes);
      logic seen_high;
      seen_high = 1'b0;
      mode         <= frame_mode;
      check_en     <= enable;
      random_notes <= with_notes;
      do begin
         @(posedge clock_65mhz);
         if (with_notes) begin
            next_notes      <= {$urandom, $urandom};
            playing_correct <= 1'($urandom);
         end
         if (vga_vsync === 1'b1)
            seen_high = 1'b1;
      end while (!(seen_high && vga_vsync === 1'b0));
   endtask

   initial begin
      void'($urandom(32'he251_1cab));
      reset           = 1'b1;
      mode            = mode_game;
      next_notes      = '0;
      // tempo is latched while reset is high
      tempo           = SHORT_TEMPO;
      playing_correct = 1'b0;
      check_en        = 1'b0;
      random_notes    = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock_65mhz);
      reset <= 1'b0;

      // lead-in frame lets the tracker find line 0
      run_frame(mode_game, 1'b0, 1'b0);
      run_frame(mode_border, 1'b1, 1'b0);
      run_frame(mode_bars, 1'b1, 1'b0);
      // rests only, then random notes
      run_frame(mode_game, 1'b1, 1'b0);
      run_frame(mode_game, 1'b1, 1'b1);

      if (pixels_checked != CHECKED_FRAMES * FRAME_PIXELS)
         $display("only %0d of %0d visible pixels were checked",
                  pixels_checked, CHECKED_FRAMES * FRAME_PIXELS);
      if (error_seen || pixels_checked != CHECKED_FRAMES * FRAME_PIXELS) begin
         $display("*** FAILED ***");
         $fatal(1, "run ended with a failed check");
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
hdl/raster_pkg.sv
hdl/note_pkg.sv
hdl/note_lane_if.sv
hdl/raster_timing.sv
hdl/note_lane.sv
hdl/note_renderer.sv
hdl/video_output.sv
hdl/rhythm_video_top.sv
testbench/rhythm_video_checks.sv
testbench/rhythm_video_tb.sv

// ==== Makefile ====
# Verilator build and run of the rhythm video testbench

SOURCES := compile.f $(wildcard include/*.svh hdl/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vrhythm_video_tb: $(SOURCES)
	verilator --binary --assert -j 0 --top-module rhythm_video_tb -f compile.f

# pass only when the pass message shows up in the output
run: obj_dir/Vrhythm_video_tb
	@out="$$(./obj_dir/Vrhythm_video_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
